/* Bender.yml */
package:
  name: packed_mac

sources:
  # packages first, geometry before the types that use it
  - hdl/dsp_geom_pkg.sv
  - hdl/packed_mac_types_pkg.sv

  # pipeline stages, then the top level
  - hdl/operand_packer.sv
  - hdl/mult_dsp_s25_s18.sv
  - hdl/packed_mac_accum.sv
  - hdl/packed_mac_pe.sv

  # testbench, the model header lives next to it
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/packed_mac_tb.sv

/* hdl/dsp_geom_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// DSP slice geometry and lane layout of the packed MAC element
//////////////////////////////////////////////////////////////////////

package dsp_geom_pkg;

  // multiplier ports, signed 25x18 slice
  localparam int A_WIDTH     = 25;
  localparam int B_WIDTH     = 18;
  localparam int P_WIDTH     = A_WIDTH + B_WIDTH;  // full product, 43 bits
  localparam int MULT_STAGES = 2;                  // input regs + product reg

  // accumulator growth per lane
  localparam int HEADROOM = 8;

  // product field spacing
  localparam int INT8_FIELD = 16;  // two s8*s8 products at 0 and 16
  localparam int INT4_FIELD = 9;   // four s4*s4 products at 0, 9, 18, 27

  // lane widths
  localparam int INT8_LANE_W = INT8_FIELD + HEADROOM;  // 24
  localparam int INT4_LANE_W = 16;
  localparam int ACC_WIDTH   = 4 * INT4_LANE_W;  // int8 fills only the low 48

  // packer reg + multiplier + accumulator reg
  localparam int PE_LATENCY = 1 + MULT_STAGES + 1;

endpackage

`default_nettype wire

/* hdl/mult_dsp_s25_s18.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_dsp_s25_s18 (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire packed_mac_types_pkg::mult_operands_t ops,
  output      packed_mac_types_pkg::product_beat_t  prod
);

  import dsp_geom_pkg::*;
  import packed_mac_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // A/B input regs then product regs
  //////////////////////////////////////////////////////////////////////
  logic signed [A_WIDTH-1:0] a_q;
  logic signed [B_WIDTH-1:0] b_q;
  logic signed [P_WIDTH-1:0] p_sr [MULT_STAGES-1];  // product pipe after input regs

  always_ff @(posedge clk) begin
    a_q     <= ops.a;
    b_q     <= ops.b;
    p_sr[0] <= a_q * b_q;  // signed, widened to P_WIDTH
    for (int i = 1; i < MULT_STAGES - 1; i++) begin
      p_sr[i] <= p_sr[i-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tag delay line matching the datapath depth
  //////////////////////////////////////////////////////////////////////
  logic [MULT_STAGES-1:0] valid_sr;
  logic [MULT_STAGES-1:0] first_sr;
  mac_mode_e              mode_sr [MULT_STAGES];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
      first_sr <= '0;
      for (int i = 0; i < MULT_STAGES; i++) begin
        mode_sr[i] <= MODE_INT8;
      end
    end else begin
      valid_sr   <= {valid_sr[MULT_STAGES-2:0], ops.valid};
      first_sr   <= {first_sr[MULT_STAGES-2:0], ops.first};
      mode_sr[0] <= ops.mode;
      for (int i = 1; i < MULT_STAGES; i++) begin
        mode_sr[i] <= mode_sr[i-1];
      end
    end
  end

  always_comb begin
    prod.valid = valid_sr[MULT_STAGES-1];
    prod.first = first_sr[MULT_STAGES-1];
    prod.mode  = mode_sr[MULT_STAGES-1];
    prod.p     = p_sr[MULT_STAGES-2];
  end

endmodule

`default_nettype wire

/* hdl/operand_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_packer (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire packed_mac_types_pkg::pe_beat_t       in_beat,
  output      packed_mac_types_pkg::mult_operands_t ops
);

  import dsp_geom_pkg::*;
  import packed_mac_types_pkg::*;

  // sign-typed views of the beat
  logic signed [7:0] pix0_s8, pix1_s8, wgt0_s8;
  logic signed [3:0] pix0_s4, pix1_s4, wgt0_s4, wgt1_s4;

  logic signed [A_WIDTH-1:0] a_d;
  logic signed [B_WIDTH-1:0] b_d;

  // true when the byte holds a sign-extended 4-bit value
  function automatic logic is_s4(input logic [7:0] v);
    return v[7:4] == {4{v[3]}};
  endfunction

  assign pix0_s8 = in_beat.pixel0;
  assign pix1_s8 = in_beat.pixel1;
  assign wgt0_s8 = in_beat.weight0;
  assign pix0_s4 = in_beat.pixel0[3:0];
  assign pix1_s4 = in_beat.pixel1[3:0];
  assign wgt0_s4 = in_beat.weight0[3:0];
  assign wgt1_s4 = in_beat.weight1[3:0];

  //////////////////////////////////////////////////////////////////////
  // operand packing
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (in_beat.mode == MODE_INT8) begin
      // pixels share A, weight alone on B
      a_d = A_WIDTH'(pix0_s8) + (A_WIDTH'(pix1_s8) <<< INT8_FIELD);
      b_d = B_WIDTH'(wgt0_s8);
    end else begin
      // weights on A at 0 and 18, pixels on B at 0 and 9
      // cross products land at 0, 9, 18, 27
      a_d = A_WIDTH'(wgt0_s4) + (A_WIDTH'(wgt1_s4) <<< (2 * INT4_FIELD));
      b_d = B_WIDTH'(pix0_s4) + (B_WIDTH'(pix1_s4) <<< INT4_FIELD);
    end
  end

  // output register, only valid is reset
  always_ff @(posedge clk) begin
    ops.first <= in_beat.first;
    ops.mode  <= in_beat.mode;
    ops.a     <= a_d;
    ops.b     <= b_d;
    if (reset) begin
      ops.valid <= 1'b0;
    end else begin
      ops.valid <= in_beat.valid;
    end
  end

  // int4 values must fit the 9-bit product fields
  int4_range_check : assert property (@(posedge clk) disable iff (reset)
    in_beat.valid && in_beat.mode == MODE_INT4 |->
      is_s4(in_beat.pixel0) && is_s4(in_beat.pixel1) &&
      is_s4(in_beat.weight0) && is_s4(in_beat.weight1))
    else $error("operand_packer: int4 operand out of 4-bit signed range");

endmodule

`default_nettype wire

/* hdl/packed_mac_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module packed_mac_accum (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire packed_mac_types_pkg::product_beat_t prod,
  output      packed_mac_types_pkg::acc_result_t   result
);

  import dsp_geom_pkg::*;
  import packed_mac_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // lane terms
  // a negative lower product borrows one from the field above it
  // adding back the lower field's sign bit undoes the borrow
  //////////////////////////////////////////////////////////////////////
  logic [INT8_LANE_W-1:0] term8 [2];  // int8 lanes
  logic [INT4_LANE_W-1:0] term4 [4];  // int4 lanes

  for (genvar k = 0; k < 2; k++) begin : g_int8_term
    logic [INT8_FIELD-1:0] fld;
    logic                  corr;

    assign fld = prod.p[k*INT8_FIELD +: INT8_FIELD];
    if (k == 0) begin : g_base
      assign corr = 1'b0;  // lowest field, nothing below
    end else begin : g_upper
      assign corr = prod.p[k*INT8_FIELD-1];
    end
    assign term8[k] = {{(INT8_LANE_W - INT8_FIELD){fld[INT8_FIELD-1]}}, fld}
                      + INT8_LANE_W'(corr);
  end

  for (genvar k = 0; k < 4; k++) begin : g_int4_term
    logic [INT4_FIELD-1:0] fld;
    logic                  corr;

    assign fld = prod.p[k*INT4_FIELD +: INT4_FIELD];
    if (k == 0) begin : g_base
      assign corr = 1'b0;
    end else begin : g_upper
      assign corr = prod.p[k*INT4_FIELD-1];  // sign of field k-1
    end
    assign term4[k] = {{(INT4_LANE_W - INT4_FIELD){fld[INT4_FIELD-1]}}, fld}
                      + INT4_LANE_W'(corr);
  end

  //////////////////////////////////////////////////////////////////////
  // lane update
  //////////////////////////////////////////////////////////////////////
  logic [ACC_WIDTH-1:0] acc_d;

  always_comb begin
    // first starts from zero, which also clears lanes the mode leaves idle
    acc_d = prod.first ? '0 : result.acc;
    if (prod.mode == MODE_INT8) begin
      for (int k = 0; k < 2; k++) begin
        acc_d[k*INT8_LANE_W +: INT8_LANE_W] =
          acc_d[k*INT8_LANE_W +: INT8_LANE_W] + term8[k];  // wraps mod 2^24
      end
    end else begin
      for (int k = 0; k < 4; k++) begin
        acc_d[k*INT4_LANE_W +: INT4_LANE_W] =
          acc_d[k*INT4_LANE_W +: INT4_LANE_W] + term4[k];  // wraps mod 2^16
      end
    end
  end

  // mode of the open window
  mac_mode_e last_mode;
  logic      have_beat;  // a beat seen since reset

  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
      result.acc   <= '0;
      last_mode    <= MODE_INT8;
      have_beat    <= 1'b0;
    end else begin
      result.valid <= prod.valid;  // one pulse per beat
      if (prod.valid) begin
        result.acc <= acc_d;
        last_mode  <= prod.mode;
        have_beat  <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // mode switches only at a window start
  mode_on_first_only : assert property (@(posedge clk) disable iff (reset)
    prod.valid && !prod.first && have_beat |-> prod.mode == last_mode)
    else $error("packed_mac_accum: mode changed inside a window");

  // bits above the top lane field only repeat the product sign
  product_in_fields : assert property (@(posedge clk) disable iff (reset)
    prod.valid |->
      ((prod.mode == MODE_INT8)
        ? (&prod.p[P_WIDTH-1:2*INT8_FIELD-1] || !(|prod.p[P_WIDTH-1:2*INT8_FIELD-1]))
        : (&prod.p[P_WIDTH-1:4*INT4_FIELD-1] || !(|prod.p[P_WIDTH-1:4*INT4_FIELD-1]))))
    else $error("packed_mac_accum: product spills above the top lane field");

endmodule

`default_nettype wire

/* hdl/packed_mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// packed MAC processing element
// in_beat -> packer (1) -> 25x18 multiplier (2) -> lane accumulator (1)
//////////////////////////////////////////////////////////////////////

module packed_mac_pe (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire packed_mac_types_pkg::pe_beat_t    in_beat,
  output      packed_mac_types_pkg::acc_result_t result
);

  import packed_mac_types_pkg::*;

  // stage links
  mult_operands_t ops;   // packer -> multiplier
  product_beat_t  prod;  // multiplier -> accumulator

  //////////////////////////////////////////////////////////////////////
  // operand packing
  //////////////////////////////////////////////////////////////////////
  operand_packer operand_packer_i (
    .clk     (clk),
    .reset   (reset),
    .in_beat (in_beat),
    .ops     (ops)
  );

  //////////////////////////////////////////////////////////////////////
  // one DSP multiply, two or four products packed
  //////////////////////////////////////////////////////////////////////
  mult_dsp_s25_s18 mult_dsp_s25_s18_i (
    .clk   (clk),
    .reset (reset),
    .ops   (ops),
    .prod  (prod)
  );

  //////////////////////////////////////////////////////////////////////
  // per-lane accumulation
  //////////////////////////////////////////////////////////////////////
  packed_mac_accum packed_mac_accum_i (
    .clk    (clk),
    .reset  (reset),
    .prod   (prod),
    .result (result)  // valid 4 cycles after in_beat
  );

endmodule

`default_nettype wire

/* hdl/packed_mac_types_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// beat and result types passed between the PE stages
//////////////////////////////////////////////////////////////////////

package packed_mac_types_pkg;

  import dsp_geom_pkg::*;

  // element precision
  typedef enum logic {
    MODE_INT8 = 1'b0,  // 2 pixels x 1 weight, s8
    MODE_INT4 = 1'b1   // 2 pixels x 2 weights, s4
  } mac_mode_e;

  // one input beat from the array
  typedef struct packed {
    logic              valid;
    logic              first;    // restart accumulation window
    mac_mode_e         mode;
    logic signed [7:0] pixel0;   // int4 uses [3:0]
    logic signed [7:0] pixel1;
    logic signed [7:0] weight0;
    logic signed [7:0] weight1;  // ignored in int8
  } pe_beat_t;

  // packed multiplier operands
  typedef struct packed {
    logic                      valid;
    logic                      first;
    mac_mode_e                 mode;
    logic signed [A_WIDTH-1:0] a;
    logic signed [B_WIDTH-1:0] b;
  } mult_operands_t;

  // raw product with its tags
  typedef struct packed {
    logic                      valid;
    logic                      first;
    mac_mode_e                 mode;
    logic signed [P_WIDTH-1:0] p;
  } product_beat_t;

  // lane k at bit 24k in int8, at bit 16k in int4
  typedef struct packed {
    logic                 valid;
    logic [ACC_WIDTH-1:0] acc;
  } acc_result_t;

endpackage

`default_nettype wire

/* packed_mac.f */
+incdir+testbench
hdl/dsp_geom_pkg.sv
hdl/packed_mac_types_pkg.sv
hdl/operand_packer.sv
hdl/mult_dsp_s25_s18.sv
hdl/packed_mac_accum.sv
hdl/packed_mac_pe.sv
testbench/packed_mac_tb.sv

/* testbench/packed_mac_model.svh */
`ifndef PACKED_MAC_MODEL_SVH
`define PACKED_MAC_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// lane sums from plain signed products, no packing involved
//////////////////////////////////////////////////////////////////////

// int8: lane0 = pixel0*weight0, lane1 = pixel1*weight0
// int4: lane0 = p0*w0, lane1 = p1*w0, lane2 = p0*w1, lane3 = p1*w1
function automatic acc_result_t next_lane_sums(
  input logic [ACC_WIDTH-1:0] prev,
  input pe_beat_t             beat
);
  acc_result_t res;
  int          prod [4];
  int          p0, p1, w0, w1;

  res.valid = 1'b1;
  res.acc   = beat.first ? '0 : prev;  // restart clears every lane

  if (beat.mode == MODE_INT8) begin
    p0      = int'($signed(beat.pixel0));
    p1      = int'($signed(beat.pixel1));
    w0      = int'($signed(beat.weight0));  // weight1 unused here
    prod[0] = p0 * w0;
    prod[1] = p1 * w0;
    for (int k = 0; k < 2; k++) begin
      res.acc[k*INT8_LANE_W +: INT8_LANE_W] =
        res.acc[k*INT8_LANE_W +: INT8_LANE_W] + INT8_LANE_W'(prod[k]);  // mod 2^24
    end
  end else begin
    p0      = int'($signed(beat.pixel0[3:0]));
    p1      = int'($signed(beat.pixel1[3:0]));
    w0      = int'($signed(beat.weight0[3:0]));
    w1      = int'($signed(beat.weight1[3:0]));
    prod[0] = p0 * w0;
    prod[1] = p1 * w0;
    prod[2] = p0 * w1;
    prod[3] = p1 * w1;
    for (int k = 0; k < 4; k++) begin
      res.acc[k*INT4_LANE_W +: INT4_LANE_W] =
        res.acc[k*INT4_LANE_W +: INT4_LANE_W] + INT4_LANE_W'(prod[k]);  // mod 2^16
    end
  end
  return res;
endfunction

`endif

/* testbench/packed_mac_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module packed_mac_tb;

  import dsp_geom_pkg::*;
  import packed_mac_types_pkg::*;

  `include "packed_mac_model.svh"

  //////////////////////////////////////////////////////////////////////
  // run shape, also sizes the watchdog
  //////////////////////////////////////////////////////////////////////
  localparam int SEED           = 41308;
  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 8;
  localparam int RAND_WINDOWS   = 12;  // per mode
  localparam int MAX_WINDOW     = 16;
  localparam int SWITCH_WINDOWS = 10;
  localparam int SWITCH_MAX     = 4;
  localparam int WRAP_WINDOWS   = 2;
  localparam int WRAP_LEN       = 1100;  // 1100 * 16384 > 2^24
  localparam int MIXED_WINDOWS  = 25;
  localparam int MIXED_MAX      = 8;
  localparam int TOTAL_BEATS    = 2 * RAND_WINDOWS * MAX_WINDOW + SWITCH_WINDOWS * SWITCH_MAX
                                  + WRAP_WINDOWS * WRAP_LEN + MIXED_WINDOWS * MIXED_MAX;
  localparam int MARGIN_CYCLES  = 200;
  localparam int TIMEOUT_NS     = (TOTAL_BEATS * PE_LATENCY + MARGIN_CYCLES) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        reset;
  pe_beat_t    in_beat;
  acc_result_t result;

  // scoreboard state
  pe_beat_t              beat_q [$];
  string                 name_q [$];
  string                 current_test = "reset_idle";
  logic [ACC_WIDTH-1:0]  model_acc    = '0;
  acc_result_t           exp_result;
  logic [PE_LATENCY-1:0] valid_hist   = '0;  // [0] newest
  logic                  result_seen  = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  packed_mac_pe packed_mac_pe_i (
    .clk     (clk),
    .reset   (reset),
    .in_beat (in_beat),
    .result  (result)
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_result(input string name, input acc_result_t exp, input acc_result_t act);
    if (act !== exp) begin
      $display("Error: %s expected valid=%0b acc=%h actual valid=%0b acc=%h",
               name, exp.valid, exp.acc, act.valid, act.acc);
      $display("Test FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected result.valid=%0b actual result.valid=%0b", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "result.valid mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic logic signed [7:0] random_s8();
    return 8'($urandom);
  endfunction

  function automatic logic signed [7:0] random_s4();
    logic [3:0] v;
    v = 4'($urandom);
    return {{4{v[3]}}, v};  // sign-extended into the byte
  endfunction

  function automatic logic signed [7:0] extreme_s8();
    return ($urandom_range(1, 0) != 0) ? 8'sh80 : 8'sh7f;
  endfunction

  task automatic drive_beat(input pe_beat_t b, input string name);
    @(posedge clk);
    in_beat <= b;
    beat_q.push_back(b);
    name_q.push_back(name);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    in_beat.valid <= 1'b0;
  endtask

  // one accumulation window, optional idle gaps after each beat
  task automatic run_window(input mac_mode_e mode, input int len, input int max_idle,
                            input bit extremes, input string name);
    pe_beat_t b;
    int       idle;

    for (int i = 0; i < len; i++) begin
      b.valid = 1'b1;
      b.first = (i == 0);
      b.mode  = mode;
      if (mode == MODE_INT4) begin
        b.pixel0  = random_s4();
        b.pixel1  = random_s4();
        b.weight0 = random_s4();
        b.weight1 = random_s4();
      end else if (extremes) begin
        b.pixel0  = 8'sh80;  // -128 * -128 every beat, lane0 wraps
        b.weight0 = 8'sh80;
        b.pixel1  = extreme_s8();
        b.weight1 = random_s8();
      end else begin
        b.pixel0  = random_s8();
        b.pixel1  = random_s8();
        b.weight0 = random_s8();
        b.weight1 = random_s8();  // ignored by int8, still random
      end
      drive_beat(b, name);
      idle = (max_idle > 0) ? $urandom_range(max_idle, 0) : 0;
      repeat (idle) drive_idle();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // scoreboard, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!reset) begin
      check_valid(current_test, valid_hist[PE_LATENCY-1], result.valid);
      if (result.valid) begin
        if (beat_q.size() == 0) begin
          $display("a result arrived with no beat outstanding, so a result was duplicated");
          $display("Test FAILED");
          $fatal(1, "unexpected result");
        end else begin
          exp_result = next_lane_sums(model_acc, beat_q.pop_front());
          model_acc  = exp_result.acc;
          check_result(name_q.pop_front(), exp_result, result);
          result_seen = 1'b1;
        end
      end else if (!result_seen) begin
        check_result("reset_idle", acc_result_t'('0), result);  // still cleared
      end
    end
    valid_hist = {valid_hist[PE_LATENCY-2:0], in_beat.valid};
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    reset   = 1'b1;
    in_beat = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    repeat (6) drive_idle();  // nothing comes out before the first beat

    current_test = "int8_random";
    repeat (RAND_WINDOWS)
      run_window(MODE_INT8, $urandom_range(MAX_WINDOW, 1), 0, 1'b0, current_test);

    current_test = "int4_random";
    repeat (RAND_WINDOWS)
      run_window(MODE_INT4, $urandom_range(MAX_WINDOW, 1), 0, 1'b0, current_test);

    // mode flips at every window start
    current_test = "mode_switch";
    for (int w = 0; w < SWITCH_WINDOWS; w++)
      run_window(mac_mode_e'(w % 2), $urandom_range(SWITCH_MAX, 1), 0, 1'b0, current_test);

    current_test = "int8_wrap";
    repeat (WRAP_WINDOWS) run_window(MODE_INT8, WRAP_LEN, 0, 1'b1, current_test);

    current_test = "mixed_idle";
    repeat (MIXED_WINDOWS)
      run_window(mac_mode_e'($urandom_range(1, 0)), $urandom_range(MIXED_MAX, 1), 3, 1'b0,
                 current_test);

    drive_idle();
    while (beat_q.size() != 0) @(posedge clk);  // drain, watchdog bounds it
    repeat (PE_LATENCY + 2) @(posedge clk);     // no stray pulse after the last one

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
